// ==== verilog/bbox_pkg.sv ====
//----------------------------------------
// Shared definitions for the bbox stage
// Fixed-point coordinate format
// Sample-mode code and vertex count
//----------------------------------------
package bbox_pkg;

    // Signed fixed point, integer part sits above RADIX
    localparam int COORD_W = 24;

    // Fraction bits of every coordinate
    localparam int RADIX = 10;

    // Code 1000 shifted by this gives 1 << RADIX, one pixel
    // Smaller codes give half, quarter and eighth pixel steps
    localparam int MSAA_SHIFT = RADIX - 3;

    // Vertices per triangle
    localparam int NUM_VERTS = 3;

    // One x or y value, a box corner component or a screen size
    typedef logic signed [COORD_W-1:0] coord_t;

    // One-hot sample mode
    // 1000 = 1x, 0100 = 4x, 0010 = 16x, 0001 = 64x
    typedef logic [3:0] msaa_t;

endpackage

// ==== verilog/bbox_extent.sv ====
//----------------------------------------
// Triangle extent
// Min and max vertex per axis
// One-hot vertex selects into the box
//----------------------------------------
`timescale 1ns/1ps

module bbox_extent (
    input  logic             clk,
    input  bbox_pkg::coord_t tri_in [bbox_pkg::NUM_VERTS-1:0][1:0],
    output bbox_pkg::coord_t raw_box [1:0][1:0]
);

    // Vertex select bits per [corner][axis]
    logic [bbox_pkg::NUM_VERTS-1:0] sel [1:0][1:0];

    always_comb begin
        for (int a = 0; a < 2; a++) begin
            // Lower-left takes the smallest value
            // Earlier vertex takes a tie so exactly one bit is set
            if ((tri_in[0][a] <= tri_in[1][a]) && (tri_in[0][a] <= tri_in[2][a])) begin
                sel[0][a] = 3'b001;
            end else if (tri_in[1][a] <= tri_in[2][a]) begin
                sel[0][a] = 3'b010;
            end else begin
                sel[0][a] = 3'b100;
            end

            // Upper-right uses the same tie rule on the largest value
            if ((tri_in[0][a] >= tri_in[1][a]) && (tri_in[0][a] >= tri_in[2][a])) begin
                sel[1][a] = 3'b001;
            end else if (tri_in[1][a] >= tri_in[2][a]) begin
                sel[1][a] = 3'b010;
            end else begin
                sel[1][a] = 3'b100;
            end
        end

        // AND-OR mux of the selected vertex coordinate
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < 2; a++) begin
                raw_box[c][a] = '0;
                for (int v = 0; v < bbox_pkg::NUM_VERTS; v++) begin
                    if (sel[c][a][v]) begin
                        raw_box[c][a] = raw_box[c][a] | tri_in[v][a];
                    end
                end
            end
        end
    end

    for (genvar a = 0; a < 2; a++) begin : g_order_chk
        // Degenerate triangles give equal corners
        assert property (@(posedge clk) raw_box[1][a] >= raw_box[0][a]);
    end

endmodule

// ==== verilog/bbox_snap.sv ====
//----------------------------------------
// Grid snap of the box corners
// Floor to the sample-mode step
//----------------------------------------
`timescale 1ns/1ps

module bbox_snap (
    input  logic             clk,
    input  bbox_pkg::coord_t raw_box [1:0][1:0],
    input  bbox_pkg::msaa_t  msaa,
    output bbox_pkg::coord_t snapped_box [1:0][1:0]
);

    // Grid step in coordinate units, 1 << RADIX for 1x
    bbox_pkg::coord_t step;
    // Fraction bits that survive the floor
    logic [bbox_pkg::RADIX-1:0] frac_mask;

    assign step = bbox_pkg::coord_t'(msaa) << bbox_pkg::MSAA_SHIFT;
    // Bits below the step are cleared, 1x keeps no fraction at all
    assign frac_mask = ~(step[bbox_pkg::RADIX-1:0] - bbox_pkg::RADIX'(1));

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < 2; a++) begin
                // Integer part passes, fraction masked
                // Two's complement makes this a floor for negatives too
                snapped_box[c][a] = {raw_box[c][a][bbox_pkg::COORD_W-1:bbox_pkg::RADIX],
                                     raw_box[c][a][bbox_pkg::RADIX-1:0] & frac_mask};
            end
        end
    end

    for (genvar c = 0; c < 2; c++) begin : g_floor_chk
        for (genvar a = 0; a < 2; a++) begin : g_axis
            // Floor only moves down, and by less than one step
            assert property (@(posedge clk)
                (snapped_box[c][a] <= raw_box[c][a]) &&
                ((raw_box[c][a] - snapped_box[c][a]) < step));
        end
    end

    // Mode code is configuration and must name one grid
    assert property (@(posedge clk) $onehot(msaa));

endmodule

// ==== verilog/bbox_clip.sv ====
//----------------------------------------
// Screen clamp and reject
// Clamp corners into the screen
// Drop triangles whose box misses it
//----------------------------------------
`timescale 1ns/1ps

module bbox_clip (
    input  logic             clk,
    input  bbox_pkg::coord_t snapped_box [1:0][1:0],
    input  bbox_pkg::coord_t screen [1:0],
    input  logic             tri_valid,
    output bbox_pkg::coord_t clipped_box [1:0][1:0],
    output logic             clip_valid
);

    // Clamped box still overlaps the screen on this axis
    logic [1:0] on_screen;

    always_comb begin
        for (int a = 0; a < 2; a++) begin
            // Lower-left below origin goes to zero
            if (snapped_box[0][a] < 0) begin
                clipped_box[0][a] = '0;
            end else begin
                clipped_box[0][a] = snapped_box[0][a];
            end

            // Upper-right past the screen goes to the last visible value
            if (snapped_box[1][a] > screen[a]) begin
                clipped_box[1][a] = screen[a];
            end else begin
                clipped_box[1][a] = snapped_box[1][a];
            end

            // A box wholly past either edge misses
            on_screen[a] = (clipped_box[0][a] <= screen[a]) &&
                           (clipped_box[1][a] >= 0);
        end
    end

    // Kept only for a real triangle that lands on screen
    assign clip_valid = tri_valid && (&on_screen);

    for (genvar a = 0; a < 2; a++) begin : g_screen_chk
        // A kept box spans the screen from its lower-left up to its upper-right
        assert property (@(posedge clk) clip_valid |->
            (clipped_box[0][a] <= clipped_box[1][a]));
    end

endmodule

// ==== verilog/bbox_pipe.sv ====
//----------------------------------------
// Stall-aware delay line
// Valid flag, box and vertices
// Only the valid bits are reset
//----------------------------------------
`timescale 1ns/1ps

module bbox_pipe #(
    parameter int PIPE_DEPTH = 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             clip_valid,
    input  bbox_pkg::coord_t clipped_box [1:0][1:0],
    input  bbox_pkg::coord_t tri_in [bbox_pkg::NUM_VERTS-1:0][1:0],
    output logic             box_valid,
    output bbox_pkg::coord_t box [1:0][1:0],
    output bbox_pkg::coord_t tri_out [bbox_pkg::NUM_VERTS-1:0][1:0]
);

    // Stage 0 is nearest the input
    logic [PIPE_DEPTH-1:0] valid_q;
    bbox_pkg::coord_t      box_q [PIPE_DEPTH-1:0][1:0][1:0];
    bbox_pkg::coord_t      tri_q [PIPE_DEPTH-1:0][bbox_pkg::NUM_VERTS-1:0][1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (!stall) begin
            valid_q[0] <= clip_valid;
            for (int s = 1; s < PIPE_DEPTH; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    // Payload advances with the valid bits and holds on stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int s = 0; s < PIPE_DEPTH; s++) begin
                for (int c = 0; c < 2; c++) begin
                    for (int a = 0; a < 2; a++) begin
                        box_q[s][c][a] <= (s == 0) ? clipped_box[c][a] : box_q[s-1][c][a];
                    end
                end
                for (int v = 0; v < bbox_pkg::NUM_VERTS; v++) begin
                    for (int a = 0; a < 2; a++) begin
                        tri_q[s][v][a] <= (s == 0) ? tri_in[v][a] : tri_q[s-1][v][a];
                    end
                end
            end
        end
    end

    assign box_valid = valid_q[PIPE_DEPTH-1];

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < 2; a++) begin
                box[c][a] = box_q[PIPE_DEPTH-1][c][a];
            end
        end
        for (int v = 0; v < bbox_pkg::NUM_VERTS; v++) begin
            for (int a = 0; a < 2; a++) begin
                tri_out[v][a] = tri_q[PIPE_DEPTH-1][v][a];
            end
        end
    end

    for (genvar a = 0; a < 2; a++) begin : g_out_chk
        // Box made by extent, snap and clip arrives well ordered
        assert property (@(posedge clk) disable iff (!rst_n)
            box_valid |-> (box[0][a] <= box[1][a]));
    end

endmodule

// ==== verilog/bbox_top.sv ====
//----------------------------------------
// Bounding-box stage top level
// Extent, snap and clip feed the
// delay line
//----------------------------------------
`timescale 1ns/1ps

module bbox_top #(
    parameter int PIPE_DEPTH = 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  bbox_pkg::coord_t tri_in [bbox_pkg::NUM_VERTS-1:0][1:0],
    input  logic             tri_valid,
    input  logic             stall,
    input  bbox_pkg::coord_t screen [1:0],
    input  bbox_pkg::msaa_t  msaa,
    output bbox_pkg::coord_t tri_out [bbox_pkg::NUM_VERTS-1:0][1:0],
    output bbox_pkg::coord_t box [1:0][1:0],
    output logic             box_valid
);

    // Combinational path, indexed [corner][axis]
    bbox_pkg::coord_t raw_box [1:0][1:0];
    bbox_pkg::coord_t snapped_box [1:0][1:0];
    bbox_pkg::coord_t clipped_box [1:0][1:0];
    logic             clip_valid;

    bbox_extent u_extent (
        .clk     (clk),
        .tri_in  (tri_in),
        .raw_box (raw_box)
    );

    bbox_snap u_snap (
        .clk         (clk),
        .raw_box     (raw_box),
        .msaa        (msaa),
        .snapped_box (snapped_box)
    );

    bbox_clip u_clip (
        .clk         (clk),
        .snapped_box (snapped_box),
        .screen      (screen),
        .tri_valid   (tri_valid),
        .clipped_box (clipped_box),
        .clip_valid  (clip_valid)
    );

    // Vertices bypass the combinational steps and ride along
    bbox_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .clip_valid  (clip_valid),
        .clipped_box (clipped_box),
        .tri_in      (tri_in),
        .box_valid   (box_valid),
        .box         (box),
        .tri_out     (tri_out)
    );

endmodule

// ==== testbench/tb_clock.sv ====
//----------------------------------------
// Testbench clock generator
// Free-running, starts low
//----------------------------------------
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        // Half period high, half period low
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// ==== testbench/bbox_tb.sv ====
//----------------------------------------
// Testbench for the bbox stage
// Reference model and output checker
// Directed tests and random stall run
// Timeout and verdict
//----------------------------------------
`timescale 1ns/1ps

module bbox_tb;

    localparam int W = bbox_pkg::COORD_W;
    localparam int DEPTH = 3;
    // Tests need a few hundred cycles
    localparam int TIMEOUT_CYCLES = 3000;

    logic             clk;
    logic             rst_n;
    bbox_pkg::coord_t tri_in [bbox_pkg::NUM_VERTS-1:0][1:0];
    logic             tri_valid;
    logic             stall;
    bbox_pkg::coord_t screen [1:0];
    bbox_pkg::msaa_t  msaa;
    bbox_pkg::coord_t tri_out [bbox_pkg::NUM_VERTS-1:0][1:0];
    bbox_pkg::coord_t box [1:0][1:0];
    logic             box_valid;

    // Expected outputs, oldest first, packed as [(index*2+axis)*W]
    logic [4*W-1:0] exp_box_q [$];
    logic [6*W-1:0] exp_tri_q [$];
    logic [4*W:0]   model_r;
    // Output state seen at the previous falling edge
    logic           held = 1'b0;
    logic           last_valid;
    logic [4*W-1:0] last_box;
    logic [6*W-1:0] last_tri;
    int             seed;
    int             cycles = 0;

    tb_clock #(.PERIOD_NS(10)) u_clock (.clk(clk));

    bbox_top #(
        .PIPE_DEPTH (DEPTH)
    ) u_bbox_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .stall     (stall),
        .screen    (screen),
        .msaa      (msaa),
        .tri_out   (tri_out),
        .box       (box),
        .box_valid (box_valid)
    );

    task automatic stop_on_error();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [W-1:0] got,
                             input logic [W-1:0] want);
        assert (got === want) else begin
            $display("ERR %s got %h expected %h", name, got, want);
            stop_on_error();
        end
    endtask

    function automatic logic [6*W-1:0] make_tri(input int x0, input int y0, input int x1,
                                                 input int y1, input int x2, input int y2);
        return {W'(y2), W'(x2), W'(y1), W'(x1), W'(y0), W'(x0)};
    endfunction

    function automatic logic [6*W-1:0] rand_tri();
        logic [6*W-1:0] t;
        int r;
        // Roughly -2400 to +2400 pixels, so some boxes clamp or miss
        for (int i = 0; i < 6; i++) begin
            r = $random(seed) % (2400 * 1024);
            t[i*W +: W] = r[W-1:0];
        end
        return t;
    endfunction

    function automatic logic [6*W-1:0] pack_tri_in();
        logic [6*W-1:0] t;
        for (int v = 0; v < bbox_pkg::NUM_VERTS; v++) begin
            for (int a = 0; a < 2; a++) begin
                t[(v*2+a)*W +: W] = tri_in[v][a];
            end
        end
        return t;
    endfunction

    function automatic logic [6*W-1:0] pack_tri_out();
        logic [6*W-1:0] t;
        for (int v = 0; v < bbox_pkg::NUM_VERTS; v++) begin
            for (int a = 0; a < 2; a++) begin
                t[(v*2+a)*W +: W] = tri_out[v][a];
            end
        end
        return t;
    endfunction

    function automatic logic [4*W-1:0] pack_box();
        logic [4*W-1:0] b;
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < 2; a++) begin
                b[(c*2+a)*W +: W] = box[c][a];
            end
        end
        return b;
    endfunction

    // Expected box from the vertices, top bit is the expected valid
    function automatic logic [4*W:0] model_box(input logic [6*W-1:0] t,
                                               input bbox_pkg::msaa_t m);
        bbox_pkg::coord_t c;
        longint lo;
        longint hi;
        longint val;
        int sh;
        logic [4*W:0] r;
        // Whole pixel for 1x, each finer mode halves the step
        sh = m[3] ? bbox_pkg::RADIX : m[2] ? bbox_pkg::RADIX - 1 :
             m[1] ? bbox_pkg::RADIX - 2 : bbox_pkg::RADIX - 3;
        r[4*W] = 1'b1;
        for (int a = 0; a < 2; a++) begin
            c = t[a*W +: W];
            lo = c;
            hi = c;
            for (int v = 1; v < bbox_pkg::NUM_VERTS; v++) begin
                c = t[(v*2+a)*W +: W];
                val = c;
                lo = (val < lo) ? val : lo;
                hi = (val > hi) ? val : hi;
            end
            // Arithmetic shift pair rounds toward minus infinity
            lo = (lo >>> sh) <<< sh;
            hi = (hi >>> sh) <<< sh;
            lo = (lo < 0) ? 0 : lo;
            hi = (hi > screen[a]) ? screen[a] : hi;
            if ((lo > screen[a]) || (hi < 0)) begin
                r[4*W] = 1'b0;
            end
            r[a*W +: W] = lo[W-1:0];
            r[(2+a)*W +: W] = hi[W-1:0];
        end
        return r;
    endfunction

    // Model takes a triangle on the same edges as the DUT
    always @(posedge clk) begin
        if (rst_n && !stall && tri_valid) begin
            model_r = model_box(pack_tri_in(), msaa);
            if (model_r[4*W]) begin
                exp_box_q.push_back(model_r[4*W-1:0]);
                exp_tri_q.push_back(pack_tri_in());
            end
        end
    end

    // Outputs settle after the rising edge, checked at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            held = 1'b0;
        end else begin
            // A stalled edge must leave every output unchanged
            if (held) begin
                check_val("box_valid", W'(box_valid), W'(last_valid));
                assert (!last_valid || (pack_box() === last_box &&
                                        pack_tri_out() === last_tri)) else begin
                    $display("ERR box %h tri_out %h changed under stall, was %h %h",
                             pack_box(), pack_tri_out(), last_box, last_tri);
                    stop_on_error();
                end
            end
            if (box_valid) begin
                assert (exp_box_q.size() != 0) else begin
                    $display("A box came out while no triangle was expected");
                    stop_on_error();
                end
                for (int c = 0; c < 2; c++) begin
                    for (int a = 0; a < 2; a++) begin
                        check_val($sformatf("box[%0d][%0d]", c, a), box[c][a],
                                  exp_box_q[0][(c*2+a)*W +: W]);
                    end
                end
                for (int v = 0; v < bbox_pkg::NUM_VERTS; v++) begin
                    for (int a = 0; a < 2; a++) begin
                        check_val($sformatf("tri_out[%0d][%0d]", v, a), tri_out[v][a],
                                  exp_tri_q[0][(v*2+a)*W +: W]);
                    end
                end
                // Downstream takes the box on the next edge unless stalled
                if (!stall) begin
                    void'(exp_box_q.pop_front());
                    void'(exp_tri_q.pop_front());
                end
            end
            held = stall;
            last_valid = box_valid;
            last_box = pack_box();
            last_tri = pack_tri_out();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("The tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    task automatic drive_tri(input logic [6*W-1:0] t, input logic v);
        for (int i = 0; i < bbox_pkg::NUM_VERTS; i++) begin
            for (int a = 0; a < 2; a++) begin
                tri_in[i][a] = t[(i*2+a)*W +: W];
            end
        end
        tri_valid = v;
    endtask

    // Present one triangle for a single edge, returns just after that edge
    task automatic send_one(input logic [6*W-1:0] t, input logic v);
        @(posedge clk);
        #1;
        drive_tri(t, v);
        @(posedge clk);
        #1;
        tri_valid = 1'b0;
    endtask

    task automatic wait_for_valid();
        do begin
            @(negedge clk);
        end while (!box_valid);
    endtask

    // Empty the pipeline, ends in the drive slot after a rising edge
    task automatic drain_pipe();
        while (exp_box_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (DEPTH + 1) @(posedge clk);
        #1;
    endtask

    task automatic low_for(input int n);
        repeat (n) begin
            @(negedge clk);
            check_val("box_valid", W'(box_valid), W'(1'b0));
        end
    endtask

    task automatic reset_check();
        low_for(5);
    endtask

    task automatic extent_and_latency();
        logic [6*W-1:0] t;
        t = make_tri(100*1024 + 256, 200*1024 + 512, 300*1024 + 768,
                     150*1024, 250*1024 + 512, 400*1024 + 128);
        send_one(t, 1'b1);
        // Taken on the last edge, visible after two more
        low_for(2);
        @(negedge clk);
        check_val("box_valid", W'(box_valid), W'(1'b1));
        check_val("box[0][0]", box[0][0], W'(100*1024));
        check_val("box[1][1]", box[1][1], W'(400*1024));
        // Same vertices without tri_valid never show up
        send_one(t, 1'b0);
        low_for(DEPTH + 1);
        drain_pipe();
    endtask

    task automatic sample_modes();
        logic [6*W-1:0] t;
        int frac [4];
        t = make_tri(100*1024 + 960, 50*1024 + 333, 140*1024 + 17,
                     90*1024 + 1000, 120*1024 + 500, 70*1024 + 5);
        // Fraction left of .9375 and .977 at steps 1, 1/2, 1/4, 1/8
        frac = '{0, 512, 768, 896};
        for (int m = 0; m < 4; m++) begin
            msaa = 4'b1000 >> m;
            send_one(t, 1'b1);
            wait_for_valid();
            check_val("box[0][0]", box[0][0], W'(100*1024 + frac[m]));
            check_val("box[1][1]", box[1][1], W'(90*1024 + frac[m]));
            drain_pipe();
        end
        msaa = 4'b1000;
    endtask

    task automatic clamp_and_reject();
        logic [6*W-1:0] t;
        logic [6*W-1:0] miss [4];
        t = make_tri(-50*1024 - 512, -20*1024 - 256, 2000*1024, 500*1024,
                     800*1024, 1200*1024 + 768);
        send_one(t, 1'b1);
        wait_for_valid();
        check_val("box[0][0]", box[0][0], W'(0));
        check_val("box[0][1]", box[0][1], W'(0));
        check_val("box[1][0]", box[1][0], screen[0]);
        check_val("box[1][1]", box[1][1], screen[1]);
        drain_pipe();
        // Left, right, below and above the screen
        miss[0] = make_tri(-300*1024, 100*1024, -10*1024 - 5, 200*1024, -100*1024, 300*1024);
        miss[1] = make_tri(1925*1024, 100*1024, 2100*1024, 200*1024, 1990*1024, 300*1024);
        miss[2] = make_tri(100*1024, -500*1024, 200*1024, -2*1024, 300*1024, -90*1024);
        miss[3] = make_tri(100*1024, 1085*1024, 200*1024, 1300*1024, 300*1024, 1100*1024);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            drive_tri(miss[i], 1'b1);
        end
        @(posedge clk);
        #1;
        tri_valid = 1'b0;
        low_for(DEPTH + 2);
        drain_pipe();
    endtask

    task automatic stall_throughput();
        int sent;
        int r;
        logic taken;
        sent = 0;
        msaa = 4'b0100;
        drive_tri(rand_tri(), 1'b1);
        r = $random(seed);
        stall = r[0];
        while (sent < 50) begin
            @(posedge clk);
            taken = tri_valid && !stall;
            #1;
            if (taken) begin
                sent++;
                if (sent < 50) begin
                    drive_tri(rand_tri(), 1'b1);
                end else begin
                    tri_valid = 1'b0;
                end
            end
            r = $random(seed);
            stall = r[0];
        end
        stall = 1'b0;
        drain_pipe();
    endtask

    initial begin
        seed = 32'hbf385ac3;
        rst_n = 1'b0;
        tri_valid = 1'b0;
        stall = 1'b0;
        msaa = 4'b1000;
        // Largest visible coordinate, 1920 x 1080 pixels
        screen[0] = W'(1919*1024);
        screen[1] = W'(1079*1024);
        for (int v = 0; v < bbox_pkg::NUM_VERTS; v++) begin
            tri_in[v][0] = '0;
            tri_in[v][1] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_check();
        extent_and_latency();
        sample_modes();
        clamp_and_reject();
        stall_throughput();
        if (exp_box_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Some expected boxes never came out of the pipeline");
            stop_on_error();
        end
    end

endmodule

// ==== list.f ====
verilog/bbox_pkg.sv
verilog/bbox_extent.sv
verilog/bbox_snap.sv
verilog/bbox_clip.sv
verilog/bbox_pipe.sv
verilog/bbox_top.sv
testbench/tb_clock.sv
testbench/bbox_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the bbox testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f list.f --top-module bbox_tb -o sim_bbox_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_bbox_tb > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if ! grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Pass line not found in sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0
